/* Bender.yml */
package:
  name: gb_alu_periph

sources:
  # Packages first, then the design bottom up
  - rtl/gb_alu_pkg.sv
  - rtl/gb_bus_pkg.sv
  - rtl/gb_alu.sv
  - rtl/gb_alu_regs.sv
  - rtl/gb_alu_periph.sv
  # Bench sources, simulation only
  - target: test
    files:
      - bench/gb_alu_asserts.sv
      - bench/gb_alu_periph_tb.sv

/* bench/gb_alu_asserts.sv */
//**************************************************
// Wishbone handshake and reset checks
// Bound into the ALU register block
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gb_alu_asserts (
	input logic clk,
	input logic arst_n,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic launch
);

	// Read by the bench at the end of the run
	int fail_count = 0;

	// Single-cycle ack
	ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack |=> !ack)
		else begin
			$error("ack high on two consecutive cycles");
			fail_count++;
		end

	// Ack answers a request from the cycle before
	ack_after_req: assert property (@(posedge clk) disable iff (!arst_n) ack |-> $past(cyc && stb))
		else begin
			$error("ack without a preceding request");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk) !arst_n |-> (!ack && !launch))
		else begin
			$error("ack or launch high during reset");
			fail_count++;
		end

endmodule

bind gb_alu_regs gb_alu_asserts gb_alu_asserts_inst (
	.clk    (clk),
	.arst_n (arst_n),
	.cyc    (wb_req.cyc),
	.stb    (wb_req.stb),
	.ack    (ack),
	.launch (launch)
);

`default_nettype wire

/* bench/gb_alu_periph_tb.sv */
//**************************************************
// Testbench for the bus-attached Game Boy ALU
// Drives Wishbone accesses, checks against ref_alu
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gb_alu_periph_tb;

	import gb_alu_pkg::*;
	import gb_bus_pkg::*;

	// Expected outputs of one operation
	typedef struct packed {
		logic [7:0]  res;
		logic [15:0] addr;
		alu_flags_t  flags;
	} ref_out_t;

	logic        clk;
	logic        arst_n;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	logic [31:0] lcg_state = 32'h3296;
	// Flag register as the bench expects it
	alu_flags_t  model_flags;

	gb_alu_periph gb_alu_periph_inst (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	// Expected result, address and flags from the ALU rules
	function automatic ref_out_t ref_alu(input logic [7:0] a, input logic [7:0] b,
			input logic [4:0] code, input alu_flags_t f);
		ref_out_t o;
		int sum;
		logic [7:0] corr;
		o = '0;
		o.flags = f;
		corr = 8'h00;
		sum = 0;
		case (code)
			ALU_AB:   o.addr = {a, b};
			ALU_B:    o.res = b;
			ALU_ADD, ALU_ADC: begin
				sum = int'(a) + int'(b) + int'((code == ALU_ADC) ? f.c : 1'b0);
				o.res = sum[7:0];
				o.flags = '{z: (o.res == 0), n: 1'b0, h: o.res[4] ^ a[4] ^ b[4], c: (sum > 255)};
			end
			ALU_SUB, ALU_SBC: begin
				sum = int'(a) - int'(b) - int'((code == ALU_SBC) ? f.c : 1'b0);
				o.res = sum[7:0];
				o.flags = '{z: (o.res == 0), n: 1'b1, h: o.res[4] ^ a[4] ^ b[4], c: (sum < 0)};
			end
			// Carry kept on INC and DEC
			ALU_INC: begin
				o.res = b + 8'd1;
				o.flags.z = (o.res == 0);
				o.flags.n = 1'b0;
				o.flags.h = o.res[4] ^ b[4];
			end
			ALU_DEC: begin
				o.res = b - 8'd1;
				o.flags.z = (o.res == 0);
				o.flags.n = 1'b1;
				o.flags.h = o.res[4] ^ b[4];
			end
			ALU_AND: begin
				o.res = a & b;
				o.flags = '{z: (o.res == 0), n: 1'b0, h: 1'b1, c: 1'b0};
			end
			ALU_OR: begin
				o.res = a | b;
				o.flags = '{z: (o.res == 0), n: 1'b0, h: 1'b0, c: 1'b0};
			end
			ALU_XOR: begin
				o.res = a ^ b;
				o.flags = '{z: (o.res == 0), n: 1'b0, h: 1'b0, c: 1'b0};
			end
			ALU_CPL: begin
				o.res = ~b;
				o.flags.n = 1'b1;
				o.flags.h = 1'b1;
			end
			ALU_SWAP: begin
				o.res = {b[3:0], b[7:4]};
				o.flags = '{z: (o.res == 0), n: 1'b0, h: 1'b0, c: 1'b0};
			end
			ALU_DAA: begin
				if (!f.n) begin
					if (f.h || (b[3:0] > 4'd9))
						corr = corr + 8'h06;
					if (f.c || (b > 8'h99)) begin
						corr = corr + 8'h60;
						o.flags.c = 1'b1;
					end
					o.res = b + corr;
				end else begin
					if (f.h)
						corr = corr + 8'h06;
					if (f.c)
						corr = corr + 8'h60;
					o.res = b - corr;
				end
				o.flags.h = 1'b0;
				o.flags.z = (o.res == 0);
			end
			// Outgoing bit goes to carry
			ALU_RLC: o = '{res: {b[6:0], b[7]}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[7]}};
			ALU_RL:  o = '{res: {b[6:0], f.c}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[7]}};
			ALU_RRC: o = '{res: {b[0], b[7:1]}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[0]}};
			ALU_RR:  o = '{res: {f.c, b[7:1]}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[0]}};
			ALU_SLA: o = '{res: {b[6:0], 1'b0}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[7]}};
			ALU_SRA: o = '{res: {b[7], b[7:1]}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[0]}};
			ALU_SRL: o = '{res: {1'b0, b[7:1]}, addr: 16'h0, flags: '{f.z, f.n, f.h, b[0]}};
			ALU_INCL: o.addr = {a, b} + 16'd1;
			ALU_DECL: o.addr = {a, b} - 16'd1;
			default: ;
		endcase
		// Shared flag rule of the shift group
		if (code >= ALU_RLC && code <= ALU_SRL) begin
			o.flags.z = (o.res == 0);
			o.flags.n = 1'b0;
			o.flags.h = 1'b0;
		end
		return o;
	endfunction

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
			$display("Errors found");
			$fatal(1, "value mismatch");
		end
	endtask

	// Sampled 10 ns after each edge
	task automatic wait_ack();
		int cycles;
		cycles = 0;
		while (!wb_rsp.ack) begin
			if (cycles == 8) begin
				$display("Timeout: the slave gave no ack within 8 cycles");
				$display("Errors found");
				$fatal(1, "bus timeout");
			end
			@(posedge clk);
			#10;
			cycles++;
		end
	endtask

	task automatic write_reg(input logic [2:0] adr, input logic [7:0] dat);
		@(posedge clk);
		#10;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		wait_ack();
		wb_req = '0;
	endtask

	task automatic read_reg(input logic [2:0] adr, output logic [7:0] dat);
		@(posedge clk);
		#10;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		wait_ack();
		dat = wb_rsp.dat;
		wb_req = '0;
	endtask

	// Strobe stays up past ack, so a second read follows two cycles later
	task automatic read_held(input logic [2:0] adr, input logic [7:0] exp);
		@(posedge clk);
		#10;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
		wait_ack();
		check_value("HELD_DAT_1", wb_rsp.dat, exp);
		@(posedge clk);
		#10;
		check_value("ACK", {7'h00, wb_rsp.ack}, 8'h00);
		@(posedge clk);
		#10;
		check_value("ACK", {7'h00, wb_rsp.ack}, 8'h01);
		check_value("HELD_DAT_2", wb_rsp.dat, exp);
		wb_req = '0;
	endtask

	// Reads all results back and compares with ref_alu
	task automatic expect_op(input logic [7:0] a, input logic [7:0] b, input logic [4:0] code);
		ref_out_t exp;
		logic [7:0] got;
		exp = ref_alu(a, b, code, model_flags);
		read_reg(REG_RES, got);
		check_value("RES", got, exp.res);
		read_reg(REG_ADDR_LO, got);
		check_value("ADDR_LO", got, exp.addr[7:0]);
		read_reg(REG_ADDR_HI, got);
		check_value("ADDR_HI", got, exp.addr[15:8]);
		read_reg(REG_FLAGS, got);
		check_value("FLAGS", got, {exp.flags, 4'h0});
		model_flags = exp.flags;
	endtask

	task automatic run_op(input logic [7:0] a, input logic [7:0] b, input logic [4:0] code,
			input logic [7:0] fl);
		write_reg(REG_OPA, a);
		write_reg(REG_OPB, b);
		write_reg(REG_FLAGS, fl);
		model_flags = alu_flags_t'(fl[7:4]);
		write_reg(REG_OP, {3'b000, code});
		expect_op(a, b, code);
	endtask

	// Flags left by the previous operation feed this one
	task automatic chain_op(input logic [7:0] a, input logic [7:0] b, input logic [4:0] code);
		write_reg(REG_OPA, a);
		write_reg(REG_OPB, b);
		write_reg(REG_OP, {3'b000, code});
		expect_op(a, b, code);
	endtask

	initial begin
		logic [7:0] got;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] fl;
		logic [4:0] code;
		arst_n = 1'b0;
		wb_req = '0;
		model_flags = '0;
		repeat (4) @(posedge clk);
		#10;
		arst_n = 1'b1;

		// Everything zero out of reset, address 7 too
		for (int adr = 0; adr < 8; adr++) begin
			read_reg(adr[2:0], got);
			check_value($sformatf("REG_%0d", adr), got, 8'h00);
		end

		// Readback, low nibble of FLAGS and top bits of OP dropped
		write_reg(REG_OPA, 8'h5A);
		write_reg(REG_OPB, 8'hC3);
		write_reg(REG_FLAGS, 8'hAF);
		read_reg(REG_OPA, got);
		check_value("OPA", got, 8'h5A);
		read_reg(REG_OPB, got);
		check_value("OPB", got, 8'hC3);
		read_reg(REG_FLAGS, got);
		check_value("FLAGS", got, 8'hA0);
		write_reg(REG_OP, 8'hE2);
		read_reg(REG_OP, got);
		check_value("OP", got, 8'h02);

		// Held strobe, ack drops for one cycle in between
		read_held(REG_OPA, 8'h5A);

		for (int i = 0; i < 400; i++) begin
			a = lcg_next();
			b = lcg_next();
			fl = lcg_next() & 8'hF0;
			code = 5'(lcg_next() % 25);
			run_op(a, b, code, fl);
		end

		// Carry out of ADD into ADC, then SLA into RL
		run_op(8'hFF, 8'h01, ALU_ADD, 8'h00);
		chain_op(8'h00, 8'h00, ALU_ADC);
		read_reg(REG_RES, got);
		check_value("RES", got, 8'h01);
		run_op(8'h00, 8'h80, ALU_SLA, 8'h00);
		chain_op(8'h00, 8'h00, ALU_RL);
		read_reg(REG_RES, got);
		check_value("RES", got, 8'h01);

		// DAA corners
		run_op(8'h00, 8'h9A, ALU_DAA, 8'h00);
		run_op(8'h00, 8'h15, ALU_DAA, 8'h20);
		run_op(8'h10, 8'h01, ALU_SUB, 8'h00);
		chain_op(8'h00, 8'h0F, ALU_DAA);
		run_op(8'h23, 8'h48, ALU_SUB, 8'h00);
		chain_op(8'h00, 8'hDB, ALU_DAA);
		run_op(8'h00, 8'h45, ALU_DAA, 8'h70);

		// Unused codes give zeros with flags held
		for (int u = 25; u < 32; u++) begin
			run_op(lcg_next(), lcg_next(), u[4:0], lcg_next() & 8'hF0);
		end

		if (gb_alu_periph_inst.gb_alu_regs_inst.gb_alu_asserts_inst.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Bus assertions failed during the run");
			$display("Errors found");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

/* rtl/gb_alu.sv */
//**************************************************
// Combinational Game Boy 8-bit ALU
// Result, 16-bit address result and next flags
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gb_alu (
	input  logic [7:0]             op_a,
	input  logic [7:0]             op_b,
	input  gb_alu_pkg::alu_op_t    op,
	input  gb_alu_pkg::alu_flags_t flags_in,
	output logic [7:0]             result,
	output logic [15:0]            addr_result,
	output gb_alu_pkg::alu_flags_t flags_out
);

	import gb_alu_pkg::*;

	// Carry-out lives in bit 8
	logic [8:0] wide;
	// DAA correction value
	logic [7:0] adj;

	always_comb begin
		// Undefined outcomes read as zero, flags held
		wide = 9'h000;
		adj = 8'h00;
		result = 8'h00;
		addr_result = 16'h0000;
		flags_out = flags_in;

		case (op)
			ALU_AB: addr_result = {op_a, op_b};

			ALU_B: result = op_b;

			// Carry-in only for ADC
			ALU_ADD, ALU_ADC: begin
				wide = {1'b0, op_a} + {1'b0, op_b} + {8'h00, (op == ALU_ADC) && flags_in.c};
				result = wide[7:0];
				flags_out.z = (result == 8'h00);
				flags_out.n = 1'b0;
				flags_out.h = result[4] ^ op_a[4] ^ op_b[4];
				flags_out.c = wide[8];
			end

			// Bit 8 is the borrow
			ALU_SUB, ALU_SBC: begin
				wide = {1'b0, op_a} - {1'b0, op_b} - {8'h00, (op == ALU_SBC) && flags_in.c};
				result = wide[7:0];
				flags_out.z = (result == 8'h00);
				flags_out.n = 1'b1;
				flags_out.h = result[4] ^ op_a[4] ^ op_b[4];
				flags_out.c = wide[8];
			end

			// INC and DEC work on B, carry untouched
			ALU_INC: begin
				result = op_b + 8'h01;
				flags_out.z = (result == 8'h00);
				flags_out.n = 1'b0;
				flags_out.h = result[4] ^ op_b[4];
			end

			ALU_DEC: begin
				result = op_b - 8'h01;
				flags_out.z = (result == 8'h00);
				flags_out.n = 1'b1;
				flags_out.h = result[4] ^ op_b[4];
			end

			// AND sets H as on the real CPU
			ALU_AND: begin
				result = op_a & op_b;
				flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
			end

			ALU_OR: begin
				result = op_a | op_b;
				flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
			end

			ALU_XOR: begin
				result = op_a ^ op_b;
				flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
			end

			// Z and C kept
			ALU_CPL: begin
				result = ~op_b;
				flags_out.n = 1'b1;
				flags_out.h = 1'b1;
			end

			// Nibble swap
			ALU_SWAP: begin
				result = {op_b[3:0], op_b[7:4]};
				flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
			end

			// N picks add or subtract correction
			ALU_DAA: begin
				if (!flags_in.n) begin
					if (flags_in.h || (op_b[3:0] > 4'h9)) begin
						adj[3:0] = 4'h6;
					end
					// Carry only ever set here, never cleared by a prior one
					if (flags_in.c || (op_b > 8'h99)) begin
						adj[7:4] = 4'h6;
						flags_out.c = 1'b1;
					end
					result = op_b + adj;
				end else begin
					if (flags_in.h) begin
						adj[3:0] = 4'h6;
					end
					if (flags_in.c) begin
						adj[7:4] = 4'h6;
					end
					result = op_b - adj;
				end
				flags_out.h = 1'b0;
				flags_out.z = (result == 8'h00);
			end

			// Bit shifted out always lands in C
			ALU_RLC, ALU_RL, ALU_RRC, ALU_RR, ALU_SLA, ALU_SRA, ALU_SRL: begin
				case (op)
					ALU_RLC: {flags_out.c, result} = {op_b, op_b[7]};
					ALU_RL:  {flags_out.c, result} = {op_b, flags_in.c};
					ALU_RRC: {result, flags_out.c} = {op_b[0], op_b};
					ALU_RR:  {result, flags_out.c} = {flags_in.c, op_b};
					ALU_SLA: {flags_out.c, result} = {op_b, 1'b0};
					// Sign bit replicated
					ALU_SRA: {result, flags_out.c} = {op_b[7], op_b};
					default: {result, flags_out.c} = {1'b0, op_b};
				endcase
				flags_out.z = (result == 8'h00);
				flags_out.n = 1'b0;
				flags_out.h = 1'b0;
			end

			// 16-bit pair step, no flag effect
			ALU_INCL: addr_result = {op_a, op_b} + 16'h0001;

			ALU_DECL: addr_result = {op_a, op_b} - 16'h0001;

			// NOP and unused codes
			default: flags_out = flags_in;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/gb_alu_periph.sv */
//**************************************************
// Bus-attached Game Boy ALU, top level
// Wishbone slave in front of the combinational ALU
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gb_alu_periph (
	input  logic                clk,
	input  logic                arst_n,
	input  gb_bus_pkg::wb_req_t wb_req,
	output gb_bus_pkg::wb_rsp_t wb_rsp
);

	import gb_alu_pkg::*;

	// Register block to ALU
	logic [7:0]  op_a;
	logic [7:0]  op_b;
	alu_op_t     op;
	alu_flags_t  flags;
	// ALU back to register block
	logic [7:0]  alu_result;
	logic [15:0] alu_addr;
	alu_flags_t  alu_flags;

	gb_alu_regs gb_alu_regs_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.wb_req     (wb_req),
		.wb_rsp     (wb_rsp),
		.op_a       (op_a),
		.op_b       (op_b),
		.op         (op),
		.flags      (flags),
		.alu_result (alu_result),
		.alu_addr   (alu_addr),
		.alu_flags  (alu_flags)
	);

	// Zero latency
	gb_alu gb_alu_inst (
		.op_a        (op_a),
		.op_b        (op_b),
		.op          (op),
		.flags_in    (flags),
		.result      (alu_result),
		.addr_result (alu_addr),
		.flags_out   (alu_flags)
	);

endmodule

`default_nettype wire

/* rtl/gb_alu_pkg.sv */
//**************************************************
// Opcode and flag types of the Game Boy ALU
// Imported by the ALU, the register block and the bench
//**************************************************
`default_nettype none

package gb_alu_pkg;

	// Opcode register is 5 bits wide
	// Codes past ALU_DECL are unused and read back as zero results
	typedef enum logic [4:0] {
		// No-op and pass
		ALU_NOP,
		ALU_AB,
		ALU_B,
		// Arithmetic
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_INC,
		ALU_DEC,
		// Logic
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_CPL,
		ALU_SWAP,
		// BCD correction
		ALU_DAA,
		// Rotates and shifts on B
		ALU_RLC,
		ALU_RL,
		ALU_RRC,
		ALU_RR,
		ALU_SLA,
		ALU_SRA,
		ALU_SRL,
		// 16-bit step on {A, B}
		ALU_INCL,
		ALU_DECL
	} alu_op_t;

	// Z N H C, same order as bits 7..4 of the F register
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} alu_flags_t;

endpackage

`default_nettype wire

/* rtl/gb_alu_regs.sv */
//**************************************************
// Wishbone register block for the ALU
// Holds operands, flags and opcode, captures results
//**************************************************
`timescale 1ns/1ns
`default_nettype none

module gb_alu_regs (
	input  logic                   clk,
	input  logic                   arst_n,
	input  gb_bus_pkg::wb_req_t    wb_req,
	output gb_bus_pkg::wb_rsp_t    wb_rsp,
	output logic [7:0]             op_a,
	output logic [7:0]             op_b,
	output gb_alu_pkg::alu_op_t    op,
	output gb_alu_pkg::alu_flags_t flags,
	input  logic [7:0]             alu_result,
	input  logic [15:0]            alu_addr,
	input  gb_alu_pkg::alu_flags_t alu_flags
);

	import gb_alu_pkg::*;
	import gb_bus_pkg::*;

	logic        ack;
	logic        access;
	// One cycle after an opcode write
	logic        launch;
	logic [7:0]  res_q;
	logic [15:0] addr_q;
	logic [7:0]  rd_dat;

	// New access only while ack is low
	assign access = wb_req.cyc && wb_req.stb && !ack;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
			launch <= 1'b0;
		end else begin
			ack <= access;
			launch <= access && wb_req.we && (wb_req.adr == REG_OP);
		end
	end

	// Writes land on the ack edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			op_a <= 8'h00;
			op_b <= 8'h00;
			op <= ALU_NOP;
			flags <= '0;
			res_q <= 8'h00;
			addr_q <= 16'h0000;
		end else begin
			if (access && wb_req.we) begin
				case (wb_req.adr)
					REG_OPA:   op_a <= wb_req.dat;
					REG_OPB:   op_b <= wb_req.dat;
					REG_FLAGS: flags <= alu_flags_t'(wb_req.dat[7:4]);
					REG_OP:    op <= alu_op_t'(wb_req.dat[4:0]);
					// Result registers ignore writes
					default: ;
				endcase
			end
			// Flags chain into the next operation
			if (launch) begin
				res_q <= alu_result;
				addr_q <= alu_addr;
				flags <= alu_flags;
			end
		end
	end

	// Read mux, address held by the master until ack
	always_comb begin
		case (wb_req.adr)
			REG_OPA:     rd_dat = op_a;
			REG_OPB:     rd_dat = op_b;
			REG_FLAGS:   rd_dat = {flags, 4'h0};
			REG_OP:      rd_dat = {3'b000, op};
			REG_RES:     rd_dat = res_q;
			REG_ADDR_LO: rd_dat = addr_q[7:0];
			REG_ADDR_HI: rd_dat = addr_q[15:8];
			default:     rd_dat = 8'h00;
		endcase
	end

	always_comb begin
		wb_rsp.ack = ack;
		wb_rsp.dat = rd_dat;
	end

endmodule

`default_nettype wire

/* rtl/gb_bus_pkg.sv */
//**************************************************
// Wishbone classic structs and register map
// Shared by the register block, the top and the bench
//**************************************************
`default_nettype none

package gb_bus_pkg;

	// Master to slave, held until ack
	typedef struct packed {
		logic       cyc;
		logic       stb;
		logic       we;
		logic [2:0] adr;
		logic [7:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// Word addresses
	// Operands and flags are read/write
	localparam logic [2:0] REG_OPA     = 3'd0;
	localparam logic [2:0] REG_OPB     = 3'd1;
	localparam logic [2:0] REG_FLAGS   = 3'd2;
	// Write launches an operation
	localparam logic [2:0] REG_OP      = 3'd3;
	// Results, read only
	localparam logic [2:0] REG_RES     = 3'd4;
	localparam logic [2:0] REG_ADDR_LO = 3'd5;
	localparam logic [2:0] REG_ADDR_HI = 3'd6;

endpackage

`default_nettype wire

/* sim.f */
rtl/gb_alu_pkg.sv
rtl/gb_bus_pkg.sv
rtl/gb_alu.sv
rtl/gb_alu_regs.sv
rtl/gb_alu_periph.sv
bench/gb_alu_asserts.sv
bench/gb_alu_periph_tb.sv
